// File: rtl/bin_store_pkg.sv
/* bin store package
   widths, RAM write records, host request and updater state encodings */
package bin_store_pkg;

    localparam int W_VAR       = 12;
    localparam int W_VSTATE    = 30;
    localparam int W_LSTATE    = 30;
    localparam int W_LVL       = 9;
    localparam int W_BIN_ID    = 6;
    localparam int W_ADDR      = 9;
    // two literal bits per variable of an 8-variable bin
    localparam int W_CLAUSE    = 16;
    localparam int W_HOST_ADDR = 12;
    localparam int W_HOST_DATA = 32;

    typedef logic [W_VAR-1:0]    var_id_t;
    typedef logic [W_VSTATE-1:0] vstate_t;
    typedef logic [W_LSTATE-1:0] lstate_t;
    typedef logic [W_LVL-1:0]    lvl_t;
    typedef logic [W_BIN_ID-1:0] bin_id_t;
    typedef logic [W_ADDR-1:0]   addr_t;
    typedef logic [W_CLAUSE-1:0] clause_t;

    // one write into the clause RAM
    typedef struct packed {
        logic    we;
        addr_t   addr;
        clause_t data;
    } clause_wr_t;

    // one write into the variable-state RAM
    typedef struct packed {
        logic    we;
        var_id_t addr;
        vstate_t data;
    } vstate_wr_t;

    // one write into the level-state RAM
    typedef struct packed {
        logic    we;
        lvl_t    addr;
        lstate_t data;
    } lstate_wr_t;

    typedef enum logic [1:0] {SEL_CLAUSE, SEL_VARID, SEL_VSTATE, SEL_LSTATE} ram_sel_e;

    typedef struct packed {
        logic                   en;
        logic                   we;
        ram_sel_e               sel;
        logic [W_HOST_ADDR-1:0] addr;
        logic [W_HOST_DATA-1:0] data;
    } host_req_t;

    typedef enum logic [1:0] {UPD_IDLE, UPD_RUN, UPD_DRAIN, UPD_DONE} upd_state_e;

endpackage

// File: rtl/bin_ram.sv
/* bin RAM
   single-port synchronous RAM, read-first, one cycle read latency */
`timescale 1ns/100ps

module bin_ram #(
    parameter int DATA_W = 16,
    parameter int DEPTH  = 512
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [DATA_W-1:0]        wdata_i,
    output logic [DATA_W-1:0]        rdata_o
);

    logic [DATA_W-1:0] mem [DEPTH];

    // old contents come out when reading and writing the same word
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

// File: rtl/update_bin.sv
/* bin updater
   writes a finished bin back: learnt clauses, variable states and level states */
`timescale 1ns/100ps

module update_bin
    import bin_store_pkg::*;
#(
    parameter int NUM_CLAUSES_A_BIN = 8,
    parameter int NUM_VARS_A_BIN    = 8,
    parameter int NUM_LVLS_A_BIN    = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start_update_i,
    input  bin_id_t                              update_bin_num_i,
    input  logic                                 local_sat_i,
    input  lvl_t                                 base_lvl_i,
    input  clause_t                              clause_i,
    input  logic [NUM_VARS_A_BIN*W_VSTATE-1:0]   var_states_i,
    input  logic [NUM_LVLS_A_BIN*W_LSTATE-1:0]   lvl_states_i,
    input  var_id_t                              varid_rdata_i,
    output logic [NUM_CLAUSES_A_BIN/2-1:0]       rd_carray_o,
    output addr_t                                varid_raddr_o,
    output clause_wr_t                           clause_wr_o,
    output vstate_wr_t                           vstate_wr_o,
    output lstate_wr_t                           lstate_wr_o,
    output logic                                 busy_o,
    output logic                                 done_update_o
);

    localparam int N_STROBE = NUM_CLAUSES_A_BIN / 2;
    localparam int CNT_W    = 4;
    // counter slots
    localparam int CNT_CLS  = 0;
    localparam int CNT_VAR  = 1;
    localparam int CNT_LVL  = 2;
    localparam int CNT_LIMIT [3] = '{N_STROBE, NUM_VARS_A_BIN, NUM_LVLS_A_BIN};

    upd_state_e                state;
    upd_state_e                state_nxt;
    bin_id_t                   bin_r;
    lvl_t                      base_lvl_r;
    addr_t                     learnt_base;
    addr_t                     var_base;
    logic [CNT_W-1:0]          cnt [3];
    logic                      cnt_done;
    logic                      var_first;
    logic [NUM_VARS_A_BIN-1:0] rd_vars;
    logic [NUM_LVLS_A_BIN-1:0] rd_lvls;
    logic                      wr_busy;
    logic                      wr_busy_q;
    vstate_t                   var_sel;
    lstate_t                   lvl_sel;

    // bins start at 1, learnt clauses go to the upper half
    assign learnt_base = addr_t'((bin_r - 1) * NUM_CLAUSES_A_BIN + 1 + N_STROBE);
    assign var_base    = addr_t'((bin_r - 1) * NUM_VARS_A_BIN + 1);

    assign busy_o        = (state == UPD_RUN) || (state == UPD_DRAIN);
    assign done_update_o = (state == UPD_DONE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= UPD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            UPD_IDLE:  if (start_update_i) state_nxt = UPD_RUN;
            UPD_RUN:   if (cnt_done) state_nxt = UPD_DRAIN;
            // wait for the last write plus one settling cycle
            UPD_DRAIN: if (!wr_busy && !wr_busy_q) state_nxt = UPD_DONE;
            default:   state_nxt = UPD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == UPD_IDLE && start_update_i) begin
            bin_r      <= update_bin_num_i;
            base_lvl_r <= base_lvl_i;
        end
    end

    // step counters for clauses, variable reads and levels
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (!rst || state != UPD_RUN) begin
                cnt[i] <= '0;
            end else if (cnt[i] != CNT_W'(CNT_LIMIT[i])) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    always_comb begin
        cnt_done = 1'b1;
        for (int i = 0; i < 3; i++) begin
            if (cnt[i] != CNT_W'(CNT_LIMIT[i])) begin
                cnt_done = 1'b0;
            end
        end
    end

    // one variable-id read per cycle
    always_ff @(posedge clk) begin
        if (state == UPD_RUN && cnt[CNT_VAR] != CNT_W'(NUM_VARS_A_BIN)) begin
            varid_raddr_o <= var_base + addr_t'(cnt[CNT_VAR]);
        end
    end

    // one-hot shifters, clause and level start together
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_carray_o <= '0;
            rd_lvls     <= '0;
            rd_vars     <= '0;
            var_first   <= 1'b0;
            wr_busy_q   <= 1'b0;
        end else begin
            if (|rd_carray_o) begin
                rd_carray_o <= rd_carray_o << 1;
            end else if (state == UPD_RUN && cnt[CNT_CLS] == '0) begin
                rd_carray_o <= N_STROBE'(1);
            end
            if (|rd_lvls) begin
                rd_lvls <= rd_lvls << 1;
            end else if (state == UPD_RUN && cnt[CNT_LVL] == '0) begin
                rd_lvls <= NUM_LVLS_A_BIN'(1);
            end
            // variable shifter lines up with the id read data
            var_first <= (state == UPD_RUN) && (cnt[CNT_VAR] == '0);
            if (|rd_vars) begin
                rd_vars <= rd_vars << 1;
            end else if (var_first) begin
                rd_vars <= NUM_VARS_A_BIN'(1);
            end
            wr_busy_q <= wr_busy;
        end
    end

    assign wr_busy = (|rd_carray_o) || (|rd_vars) || (|rd_lvls) || var_first;

    // slot select from the flat state vectors
    always_comb begin
        var_sel = '0;
        for (int j = 0; j < NUM_VARS_A_BIN; j++) begin
            if (rd_vars[j]) begin
                var_sel = var_sel | var_states_i[j*W_VSTATE +: W_VSTATE];
            end
        end
    end

    always_comb begin
        lvl_sel = '0;
        for (int j = 0; j < NUM_LVLS_A_BIN; j++) begin
            if (rd_lvls[j]) begin
                lvl_sel = lvl_sel | lvl_states_i[j*W_LSTATE +: W_LSTATE];
            end
        end
    end

    // registered writes, states only on a local SAT result
    always_ff @(posedge clk) begin
        clause_wr_o.data <= clause_i;
        if (rd_carray_o[0]) begin
            clause_wr_o.addr <= learnt_base;
        end else if (|rd_carray_o) begin
            clause_wr_o.addr <= clause_wr_o.addr + 1'b1;
        end
        vstate_wr_o.addr <= varid_rdata_i;
        vstate_wr_o.data <= var_sel;
        lstate_wr_o.data <= lvl_sel;
        if (rd_lvls[0]) begin
            lstate_wr_o.addr <= base_lvl_r + 1'b1;
        end else if (|rd_lvls) begin
            lstate_wr_o.addr <= lstate_wr_o.addr + 1'b1;
        end
        if (!rst) begin
            clause_wr_o.we <= 1'b0;
            vstate_wr_o.we <= 1'b0;
            lstate_wr_o.we <= 1'b0;
        end else begin
            clause_wr_o.we <= |rd_carray_o;
            vstate_wr_o.we <= (|rd_vars) && local_sat_i;
            lstate_wr_o.we <= (|rd_lvls) && local_sat_i;
        end
    end

    a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(rd_carray_o) && $onehot0(rd_vars) && $onehot0(rd_lvls));

    a_done_after_busy: assert property (@(posedge clk) disable iff (!rst)
        done_update_o |-> $past(busy_o));

    a_write_in_busy: assert property (@(posedge clk) disable iff (!rst)
        (clause_wr_o.we || vstate_wr_o.we || lstate_wr_o.we) |-> busy_o);

endmodule

// File: rtl/bin_port_mux.sv
/* bin port mux
   hands each RAM port to the updater while busy, otherwise to the host */
`timescale 1ns/100ps

module bin_port_mux
    import bin_store_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   busy_i,
    input  host_req_t              host_req_i,
    input  clause_wr_t             clause_wr_i,
    input  vstate_wr_t             vstate_wr_i,
    input  lstate_wr_t             lstate_wr_i,
    input  addr_t                  varid_raddr_i,
    output logic                   clause_we_o,
    output addr_t                  clause_addr_o,
    output clause_t                clause_wdata_o,
    output logic                   varid_we_o,
    output addr_t                  varid_addr_o,
    output var_id_t                varid_wdata_o,
    output logic                   vstate_we_o,
    output var_id_t                vstate_addr_o,
    output vstate_t                vstate_wdata_o,
    output logic                   lstate_we_o,
    output lvl_t                   lstate_addr_o,
    output lstate_t                lstate_wdata_o,
    input  clause_t                clause_rdata_i,
    input  var_id_t                varid_rdata_i,
    input  vstate_t                vstate_rdata_i,
    input  lstate_t                lstate_rdata_i,
    output logic [W_HOST_DATA-1:0] host_rdata_o
);

    logic     host_wr;
    ram_sel_e rd_sel_q;

    assign host_wr = host_req_i.en && host_req_i.we;

    always_comb begin
        // host defaults, truncated to each RAM
        clause_we_o    = host_wr && (host_req_i.sel == SEL_CLAUSE);
        clause_addr_o  = host_req_i.addr[W_ADDR-1:0];
        clause_wdata_o = host_req_i.data[W_CLAUSE-1:0];
        varid_we_o     = host_wr && (host_req_i.sel == SEL_VARID);
        varid_addr_o   = host_req_i.addr[W_ADDR-1:0];
        varid_wdata_o  = host_req_i.data[W_VAR-1:0];
        vstate_we_o    = host_wr && (host_req_i.sel == SEL_VSTATE);
        vstate_addr_o  = host_req_i.addr;
        vstate_wdata_o = host_req_i.data[W_VSTATE-1:0];
        lstate_we_o    = host_wr && (host_req_i.sel == SEL_LSTATE);
        lstate_addr_o  = host_req_i.addr[W_LVL-1:0];
        lstate_wdata_o = host_req_i.data[W_LSTATE-1:0];
        if (busy_i) begin
            {clause_we_o, clause_addr_o, clause_wdata_o} = clause_wr_i;
            {vstate_we_o, vstate_addr_o, vstate_wdata_o} = vstate_wr_i;
            {lstate_we_o, lstate_addr_o, lstate_wdata_o} = lstate_wr_i;
            // updater only reads the id RAM
            varid_we_o   = 1'b0;
            varid_addr_o = varid_raddr_i;
        end
    end

    // remember which RAM the host read, data comes back next cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_sel_q <= SEL_CLAUSE;
        end else if (host_req_i.en) begin
            rd_sel_q <= host_req_i.sel;
        end
    end

    always_comb begin
        case (rd_sel_q)
            SEL_CLAUSE: host_rdata_o = W_HOST_DATA'(clause_rdata_i);
            SEL_VARID:  host_rdata_o = W_HOST_DATA'(varid_rdata_i);
            SEL_VSTATE: host_rdata_o = W_HOST_DATA'(vstate_rdata_i);
            default:    host_rdata_o = W_HOST_DATA'(lstate_rdata_i);
        endcase
    end

    // a host write during busy reaches no RAM, only updater writes do
    a_no_host_write_busy: assert property (@(posedge clk) disable iff (!rst)
        busy_i && host_wr |-> !varid_we_o
            && !(clause_we_o && !clause_wr_i.we)
            && !(vstate_we_o && !vstate_wr_i.we)
            && !(lstate_we_o && !lstate_wr_i.we));

endmodule

// File: rtl/bin_store.sv
/* bin store top
   four bin RAMs shared between the host port and the bin updater */
`timescale 1ns/100ps

module bin_store
    import bin_store_pkg::*;
#(
    parameter int NUM_CLAUSES_A_BIN = 8,
    parameter int NUM_VARS_A_BIN    = 8,
    parameter int NUM_LVLS_A_BIN    = 8
) (
    input  logic                               clk,
    input  logic                               rst,
    input  host_req_t                          host_req_i,
    output logic [W_HOST_DATA-1:0]             host_rdata_o,
    input  logic                               start_update_i,
    input  bin_id_t                            update_bin_num_i,
    input  logic                               local_sat_i,
    input  lvl_t                               base_lvl_i,
    input  clause_t                            clause_i,
    input  logic [NUM_VARS_A_BIN*W_VSTATE-1:0] var_states_i,
    input  logic [NUM_LVLS_A_BIN*W_LSTATE-1:0] lvl_states_i,
    output logic [NUM_CLAUSES_A_BIN/2-1:0]     rd_carray_o,
    output logic                               busy_o,
    output logic                               done_update_o
);

    clause_wr_t clause_wr;
    vstate_wr_t vstate_wr;
    lstate_wr_t lstate_wr;
    addr_t      varid_raddr;

    // RAM port wires
    logic    clause_we;
    addr_t   clause_addr;
    clause_t clause_wdata;
    clause_t clause_rdata;
    logic    varid_we;
    addr_t   varid_addr;
    var_id_t varid_wdata;
    var_id_t varid_rdata;
    logic    vstate_we;
    var_id_t vstate_addr;
    vstate_t vstate_wdata;
    vstate_t vstate_rdata;
    logic    lstate_we;
    lvl_t    lstate_addr;
    lstate_t lstate_wdata;
    lstate_t lstate_rdata;

    update_bin #(
        .NUM_CLAUSES_A_BIN (NUM_CLAUSES_A_BIN),
        .NUM_VARS_A_BIN    (NUM_VARS_A_BIN),
        .NUM_LVLS_A_BIN    (NUM_LVLS_A_BIN)
    ) i_update_bin (
        .clk              (clk),
        .rst              (rst),
        .start_update_i   (start_update_i),
        .update_bin_num_i (update_bin_num_i),
        .local_sat_i      (local_sat_i),
        .base_lvl_i       (base_lvl_i),
        .clause_i         (clause_i),
        .var_states_i     (var_states_i),
        .lvl_states_i     (lvl_states_i),
        .varid_rdata_i    (varid_rdata),
        .rd_carray_o      (rd_carray_o),
        .varid_raddr_o    (varid_raddr),
        .clause_wr_o      (clause_wr),
        .vstate_wr_o      (vstate_wr),
        .lstate_wr_o      (lstate_wr),
        .busy_o           (busy_o),
        .done_update_o    (done_update_o)
    );

    bin_port_mux i_port_mux (
        .clk            (clk),
        .rst            (rst),
        .busy_i         (busy_o),
        .host_req_i     (host_req_i),
        .clause_wr_i    (clause_wr),
        .vstate_wr_i    (vstate_wr),
        .lstate_wr_i    (lstate_wr),
        .varid_raddr_i  (varid_raddr),
        .clause_we_o    (clause_we),
        .clause_addr_o  (clause_addr),
        .clause_wdata_o (clause_wdata),
        .varid_we_o     (varid_we),
        .varid_addr_o   (varid_addr),
        .varid_wdata_o  (varid_wdata),
        .vstate_we_o    (vstate_we),
        .vstate_addr_o  (vstate_addr),
        .vstate_wdata_o (vstate_wdata),
        .lstate_we_o    (lstate_we),
        .lstate_addr_o  (lstate_addr),
        .lstate_wdata_o (lstate_wdata),
        .clause_rdata_i (clause_rdata),
        .varid_rdata_i  (varid_rdata),
        .vstate_rdata_i (vstate_rdata),
        .lstate_rdata_i (lstate_rdata),
        .host_rdata_o   (host_rdata_o)
    );

    bin_ram #(.DATA_W(W_CLAUSE), .DEPTH(2**W_ADDR)) i_clause_ram (
        .clk     (clk),
        .we_i    (clause_we),
        .addr_i  (clause_addr),
        .wdata_i (clause_wdata),
        .rdata_o (clause_rdata)
    );

    bin_ram #(.DATA_W(W_VAR), .DEPTH(2**W_ADDR)) i_varid_ram (
        .clk     (clk),
        .we_i    (varid_we),
        .addr_i  (varid_addr),
        .wdata_i (varid_wdata),
        .rdata_o (varid_rdata)
    );

    // indexed directly by variable id
    bin_ram #(.DATA_W(W_VSTATE), .DEPTH(2**W_VAR)) i_vstate_ram (
        .clk     (clk),
        .we_i    (vstate_we),
        .addr_i  (vstate_addr),
        .wdata_i (vstate_wdata),
        .rdata_o (vstate_rdata)
    );

    bin_ram #(.DATA_W(W_LSTATE), .DEPTH(2**W_LVL)) i_lstate_ram (
        .clk     (clk),
        .we_i    (lstate_we),
        .addr_i  (lstate_addr),
        .wdata_i (lstate_wdata),
        .rdata_o (lstate_rdata)
    );

endmodule

// File: tests/tb_bin_store.sv
/* bin store testbench
   preloads the RAMs over the host port, models the solver engine for a series of
   bin updates and reads every RAM back against a reference model */
`timescale 1ns/100ps

module tb_bin_store
    import bin_store_pkg::*;
();

    localparam int NCL         = 8;
    localparam int NVAR        = 8;
    localparam int NLVL        = 8;
    localparam int N_RAND_UPD  = 9;
    localparam int N_UPD       = 3 + N_RAND_UPD;
    localparam int UPD_TIMEOUT = 40;
    localparam int D_CLAUSE    = 2**W_ADDR;
    localparam int D_VARID     = 2**W_ADDR;
    localparam int D_VSTATE    = 2**W_VAR;
    localparam int D_LSTATE    = 2**W_LVL;
    localparam int EARLY_RD    = 64;
    // preload, early readback and final readback over the host port
    localparam int HOST_LEN    = 2 * (D_CLAUSE + D_VARID + D_VSTATE + D_LSTATE) + 4 * EARLY_RD;
    localparam int WD_CYCLES   = N_UPD * 40 + HOST_LEN * 2 + 200;

    logic                     clk;
    logic                     rst;
    host_req_t                host_req_i;
    logic [W_HOST_DATA-1:0]   host_rdata_o;
    logic                     start_update_i;
    bin_id_t                  update_bin_num_i;
    logic                     local_sat_i;
    lvl_t                     base_lvl_i;
    clause_t                  clause_i;
    logic [NVAR*W_VSTATE-1:0] var_states_i;
    logic [NLVL*W_LSTATE-1:0] lvl_states_i;
    logic [NCL/2-1:0]         rd_carray_o;
    logic                     busy_o;
    logic                     done_update_o;

    logic [31:0] seed = 32'hcf36;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          done_cnt = 0;

    // reference contents and the engine's data for the current update
    clause_t exp_clause [D_CLAUSE];
    var_id_t exp_varid [D_VARID];
    vstate_t exp_vstate [D_VSTATE];
    lstate_t exp_lstate [D_LSTATE];
    clause_t cur_clause [NCL/2];
    vstate_t cur_vstate [NVAR];
    lstate_t cur_lstate [NLVL];

    // host read in flight, compared one cycle later
    logic                   rd_q_valid = 1'b0;
    ram_sel_e               rd_q_sel;
    logic [W_HOST_ADDR-1:0] rd_q_addr;

    bin_store #(
        .NUM_CLAUSES_A_BIN (NCL),
        .NUM_VARS_A_BIN    (NVAR),
        .NUM_LVLS_A_BIN    (NLVL)
    ) i_dut (
        .clk              (clk),
        .rst              (rst),
        .host_req_i       (host_req_i),
        .host_rdata_o     (host_rdata_o),
        .start_update_i   (start_update_i),
        .update_bin_num_i (update_bin_num_i),
        .local_sat_i      (local_sat_i),
        .base_lvl_i       (base_lvl_i),
        .clause_i         (clause_i),
        .var_states_i     (var_states_i),
        .lvl_states_i     (lvl_states_i),
        .rd_carray_o      (rd_carray_o),
        .busy_o           (busy_o),
        .done_update_o    (done_update_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);
    endfunction

    // fill patterns, each uses every address bit
    function automatic clause_t fill_clause(input addr_t a);
        return {a, ~a[6:0]};
    endfunction

    function automatic vstate_t fill_vstate(input var_id_t a);
        return {6'h2a, a, ~a};
    endfunction

    function automatic lstate_t fill_lstate(input lvl_t a);
        return {3'h5, a, ~a, a ^ 9'h0f3};
    endfunction

    // write-back rules applied to the reference RAMs
    function automatic void apply_update(input int bin, input logic sat, input lvl_t base);
        int b;
        int v;
        b = (bin - 1) * NCL + 1;
        v = (bin - 1) * NVAR + 1;
        for (int k = 0; k < NCL / 2; k++) begin
            exp_clause[b + NCL / 2 + k] = cur_clause[k];
        end
        if (sat) begin
            for (int j = 0; j < NVAR; j++) begin
                exp_vstate[exp_varid[v + j]] = cur_vstate[j];
            end
            for (int j = 0; j < NLVL; j++) begin
                exp_lstate[lvl_t'(base + 1 + j)] = cur_lstate[j];
            end
        end
    endfunction

    function automatic logic [31:0] exp_word(input ram_sel_e sel, input int a);
        case (sel)
            SEL_CLAUSE: return 32'(exp_clause[a]);
            SEL_VARID:  return 32'(exp_varid[a]);
            SEL_VSTATE: return 32'(exp_vstate[a]);
            default:    return 32'(exp_lstate[a]);
        endcase
    endfunction

    function automatic host_req_t host_cmd(input logic we, input ram_sel_e sel, input int a,
                                           input logic [31:0] data);
        host_req_t r;
        r.en   = 1'b1;
        r.we   = we;
        r.sel  = sel;
        r.addr = W_HOST_ADDR'(a);
        r.data = data;
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        a_check: assert (act === exp) else begin
            err_cnt++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // engine model, learnt clause k answers strobe bit k in the same cycle
    always_comb begin
        clause_i = '0;
        for (int k = 0; k < NCL / 2; k++) begin
            if (rd_carray_o[k]) begin
                clause_i = cur_clause[k];
            end
        end
    end

    // compares host read data one cycle after each read request
    always @(posedge clk) begin
        if (rd_q_valid) begin
            check_eq($sformatf("host_rdata_o sel %0d addr %0h", rd_q_sel, rd_q_addr),
                     exp_word(rd_q_sel, rd_q_addr), host_rdata_o);
        end
        rd_q_valid <= rst && host_req_i.en && !host_req_i.we;
        rd_q_sel   <= host_req_i.sel;
        rd_q_addr  <= host_req_i.addr;
    end

    always @(posedge clk) begin
        if (rst && done_update_o) begin
            done_cnt++;
        end
    end

    task automatic host_write(input ram_sel_e sel, input int a, input logic [31:0] data);
        host_req_i <= host_cmd(1'b1, sel, a, data);
        @(posedge clk);
    endtask

    task automatic preload_rams();
        bit      used [D_VSTATE];
        var_id_t id;
        for (int a = 0; a < D_CLAUSE; a++) begin
            exp_clause[a] = fill_clause(addr_t'(a));
            host_write(SEL_CLAUSE, a, 32'(exp_clause[a]));
        end
        // distinct random variable ids
        for (int a = 0; a < D_VARID; a++) begin
            id = var_id_t'(next_rand());
            while (used[id]) begin
                id = var_id_t'(next_rand());
            end
            used[id] = 1'b1;
            exp_varid[a] = id;
            host_write(SEL_VARID, a, 32'(id));
        end
        for (int a = 0; a < D_VSTATE; a++) begin
            exp_vstate[a] = fill_vstate(var_id_t'(a));
            host_write(SEL_VSTATE, a, 32'(exp_vstate[a]));
        end
        for (int a = 0; a < D_LSTATE; a++) begin
            exp_lstate[a] = fill_lstate(lvl_t'(a));
            host_write(SEL_LSTATE, a, 32'(exp_lstate[a]));
        end
        host_req_i <= '0;
        @(posedge clk);
    endtask

    task automatic read_back(input ram_sel_e sel, input int first, input int count);
        for (int a = first; a < first + count; a++) begin
            host_req_i <= host_cmd(1'b0, sel, a, '0);
            @(posedge clk);
        end
        host_req_i <= '0;
        repeat (2) @(posedge clk);
    endtask

    // one bin update, entered and left on a rising edge
    task automatic run_update(input bin_id_t bin, input logic sat, input logic poke);
        logic [NVAR*W_VSTATE-1:0] vs_flat;
        logic [NLVL*W_LSTATE-1:0] ls_flat;
        lvl_t                     base;
        int                       poke_a;
        int                       cycles;
        int                       strobes;
        bit                       seen_done;
        base = lvl_t'(next_rand());
        poke_a = (bin - 1) * NVAR + 1;
        for (int k = 0; k < NCL / 2; k++) begin
            cur_clause[k] = clause_t'(next_rand());
        end
        for (int j = 0; j < NVAR; j++) begin
            cur_vstate[j] = vstate_t'(next_rand());
            vs_flat[j*W_VSTATE +: W_VSTATE] = cur_vstate[j];
        end
        for (int j = 0; j < NLVL; j++) begin
            cur_lstate[j] = lstate_t'(next_rand());
            ls_flat[j*W_LSTATE +: W_LSTATE] = cur_lstate[j];
        end
        update_bin_num_i <= bin;
        local_sat_i      <= sat;
        base_lvl_i       <= base;
        var_states_i     <= vs_flat;
        lvl_states_i     <= ls_flat;
        start_update_i   <= 1'b1;
        @(posedge clk);
        start_update_i <= 1'b0;
        cycles = 0;
        strobes = 0;
        seen_done = 1'b0;
        while (!seen_done && cycles < UPD_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (done_update_o) begin
                seen_done = 1'b1;
                check_eq("busy_o at done", 0, busy_o);
            end else begin
                check_eq("busy_o", 1, busy_o);
                if (rd_carray_o != '0) begin
                    check_eq("rd_carray_o", 32'(1) << strobes, 32'(rd_carray_o));
                    strobes++;
                end
                // second start and a host write, both must be ignored while busy
                if (poke && cycles == 3) begin
                    start_update_i <= 1'b1;
                    host_req_i     <= host_cmd(1'b1, SEL_VARID, poke_a, 32'(~exp_varid[poke_a]));
                end else if (poke && cycles == 4) begin
                    start_update_i <= 1'b0;
                    host_req_i     <= '0;
                end
            end
        end
        if (!seen_done) begin
            err_cnt++;
            $display("update of bin %0d gave no done pulse within %0d cycles", bin, UPD_TIMEOUT);
        end else begin
            check_eq("rd_carray_o strobe count", NCL / 2, strobes);
            apply_update(bin, sat, base);
        end
    endtask

    initial begin
        bin_id_t bin;
        logic    sat;
        rst              = 1'b0;
        host_req_i       = '0;
        start_update_i   = 1'b0;
        update_bin_num_i = '0;
        local_sat_i      = 1'b0;
        base_lvl_i       = '0;
        var_states_i     = '0;
        lvl_states_i     = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        check_eq("busy_o", 0, busy_o);
        check_eq("done_update_o", 0, done_update_o);
        check_eq("rd_carray_o", 0, 32'(rd_carray_o));
        preload_rams();
        read_back(SEL_CLAUSE, 0, EARLY_RD);
        read_back(SEL_VARID, 0, EARLY_RD);
        read_back(SEL_VSTATE, 0, EARLY_RD);
        read_back(SEL_LSTATE, 0, EARLY_RD);
        // directed bins, then random ones back to back
        run_update(1, 1'b1, 1'b0);
        run_update(2, 1'b0, 1'b0);
        run_update(3, 1'b1, 1'b1);
        for (int n = 0; n < N_RAND_UPD; n++) begin
            bin = bin_id_t'(1 + next_rand() % 63);
            sat = (next_rand() % 4) != 0;
            run_update(bin, sat, 1'b0);
        end
        read_back(SEL_CLAUSE, 0, D_CLAUSE);
        read_back(SEL_VARID, 0, D_VARID);
        read_back(SEL_VSTATE, 0, D_VSTATE);
        read_back(SEL_LSTATE, 0, D_LSTATE);
        check_eq("done_update_o pulses", N_UPD, done_cnt);
        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", WD_CYCLES);
        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: bin_store.f
rtl/bin_store_pkg.sv
rtl/bin_ram.sv
rtl/update_bin.sv
rtl/bin_port_mux.sv
rtl/bin_store.sv
tests/tb_bin_store.sv
